// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [31:0] word_t;

	// field positions in the instruction word
	localparam int OPCODE_LSB = 25;
	localparam int RT_LSB = 20;
	localparam int RA_LSB = 15;
	localparam int RB_LSB = 10;

	// immediate widths, both sign extended
	localparam int IMM15_WIDTH = 15;
	localparam int BOFS_WIDTH = 14;

	// major opcodes, bits 30..25
	typedef enum logic [5:0] {
		OP_ALU  = 6'h00,
		OP_LW   = 6'h02,
		OP_ADDI = 6'h08,
		OP_SW   = 6'h0a,
		OP_BEQ  = 6'h24,
		OP_HALT = 6'h3f
	} opcode_t;

	// sub-operation of OP_ALU, bits 4..0
	typedef enum logic [4:0] {
		ALU_ADD = 5'h00,
		ALU_SUB = 5'h01,
		ALU_AND = 5'h02,
		ALU_XOR = 5'h03,
		ALU_OR  = 5'h04,
		ALU_SLT = 5'h06
	} alu_op_t;

endpackage

`default_nettype wire

// ==== logic/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	// byte address, word aligned accesses only
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// pc step and branch offset scale
	localparam int WORD_BYTES = 4;

endpackage

`default_nettype wire

// ==== logic/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic clock,
	input  logic rst,
	input  isa_pkg::reg_addr_t rd_addr_a,
	input  isa_pkg::reg_addr_t rd_addr_b,
	input  logic wr_en,
	input  isa_pkg::reg_addr_t wr_addr,
	input  isa_pkg::word_t wr_data,
	output isa_pkg::word_t rd_data_a,
	output isa_pkg::word_t rd_data_b
);
	import isa_pkg::*;

	localparam int NUM_REGS = 2 ** $bits(reg_addr_t);

	// r0 is not hardwired
	word_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// async reads
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter bus_pkg::addr_t RESET_PC = '0
) (
	input  logic clock,
	input  logic rst,
	input  logic retire,
	input  bus_pkg::addr_t next_pc,
	input  bus_pkg::data_t ibus_dat_r,
	input  logic ibus_ack,
	output logic ibus_cyc,
	output logic ibus_stb,
	output bus_pkg::addr_t ibus_adr,
	output logic instr_valid,
	output isa_pkg::instr_t instr,
	output bus_pkg::addr_t pc
);
	import bus_pkg::*;

	typedef enum logic [1:0] {
		F_IDLE,
		F_FETCH,
		F_HOLD
	} fetch_state_t;

	fetch_state_t state;
	addr_t pc_q;
	data_t instr_q;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= F_IDLE;
			pc_q <= RESET_PC;
		end else begin
			case (state)
				// first read right after reset
				F_IDLE: state <= F_FETCH;
				F_FETCH: begin
					if (ibus_ack) begin
						state <= F_HOLD;
					end
				end
				F_HOLD: begin
					if (retire) begin
						pc_q <= next_pc;
						state <= F_FETCH;
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	// instruction word, kept until the core retires it
	always_ff @(posedge clock) begin
		if (state == F_FETCH && ibus_ack) begin
			instr_q <= ibus_dat_r;
		end
	end

	assign ibus_cyc = (state == F_FETCH);
	assign ibus_stb = (state == F_FETCH);
	assign ibus_adr = pc_q;

	assign instr_valid = (state == F_HOLD);
	assign instr = instr_q;
	assign pc = pc_q;

endmodule

`default_nettype wire

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  logic clock,
	input  logic rst,
	input  logic instr_valid,
	input  isa_pkg::instr_t instr,
	input  bus_pkg::addr_t pc,
	input  isa_pkg::word_t rd_data_a,
	input  isa_pkg::word_t rd_data_b,
	input  logic mem_done,
	input  bus_pkg::data_t mem_rdata,
	output logic retire,
	output bus_pkg::addr_t next_pc,
	output isa_pkg::reg_addr_t rd_addr_a,
	output isa_pkg::reg_addr_t rd_addr_b,
	output logic wr_en,
	output isa_pkg::reg_addr_t wr_addr,
	output isa_pkg::word_t wr_data,
	output logic mem_req,
	output logic mem_write,
	output bus_pkg::addr_t mem_addr,
	output bus_pkg::data_t mem_wdata,
	output logic alu_overflow
);
	import isa_pkg::*;
	import bus_pkg::*;

	typedef enum logic [1:0] {
		S_WAIT,
		S_EXEC,
		S_MEM,
		S_HALT
	} exec_state_t;

	exec_state_t state;
	opcode_t opcode;
	alu_op_t alu_op;
	reg_addr_t rt;
	reg_addr_t ra;
	reg_addr_t rb;
	word_t imm_ext;
	addr_t bofs_ext;
	word_t src_b;
	word_t sum;
	word_t diff;
	word_t alu_result;
	logic add_ovf;
	logic sub_ovf;
	logic ovf_now;
	logic is_mem;
	logic writes_rt;
	logic branch_taken;

	// field decode
	assign opcode = opcode_t'(instr[OPCODE_LSB +: $bits(opcode_t)]);
	assign alu_op = alu_op_t'(instr[$bits(alu_op_t)-1:0]);
	assign rt = instr[RT_LSB +: $bits(reg_addr_t)];
	assign ra = instr[RA_LSB +: $bits(reg_addr_t)];
	assign rb = instr[RB_LSB +: $bits(reg_addr_t)];
	assign imm_ext = {{($bits(word_t) - IMM15_WIDTH){instr[IMM15_WIDTH-1]}},
		instr[IMM15_WIDTH-1:0]};
	assign bofs_ext = {{($bits(addr_t) - BOFS_WIDTH){instr[BOFS_WIDTH-1]}},
		instr[BOFS_WIDTH-1:0]};

	// rb only matters for register ALU ops, stores and beq read rt
	assign rd_addr_a = ra;
	assign rd_addr_b = (opcode == OP_ALU) ? rb : rt;

	assign src_b = (opcode == OP_ADDI) ? imm_ext : rd_data_b;
	assign sum = rd_data_a + src_b;
	assign diff = rd_data_a - src_b;

	// signed overflow
	assign add_ovf = (rd_data_a[31] == src_b[31]) && (sum[31] != rd_data_a[31]);
	assign sub_ovf = (rd_data_a[31] != src_b[31]) && (diff[31] != rd_data_a[31]);
	assign ovf_now = (opcode == OP_ADDI && add_ovf) ||
		(opcode == OP_ALU && alu_op == ALU_ADD && add_ovf) ||
		(opcode == OP_ALU && alu_op == ALU_SUB && sub_ovf);

	always_comb begin
		alu_result = '0;
		if (opcode == OP_ADDI) begin
			alu_result = sum;
		end else begin
			case (alu_op)
				ALU_ADD: alu_result = sum;
				ALU_SUB: alu_result = diff;
				ALU_AND: alu_result = rd_data_a & src_b;
				ALU_OR:  alu_result = rd_data_a | src_b;
				ALU_XOR: alu_result = rd_data_a ^ src_b;
				ALU_SLT: alu_result = word_t'($signed(rd_data_a) < $signed(src_b));
				// unknown sub-op writes zero
				default: alu_result = '0;
			endcase
		end
	end

	assign is_mem = (opcode == OP_LW) || (opcode == OP_SW);
	assign writes_rt = (opcode == OP_ALU) || (opcode == OP_ADDI) || (opcode == OP_LW);

	// beq compares rt with ra
	assign branch_taken = (opcode == OP_BEQ) && (rd_data_b == rd_data_a);
	assign next_pc = branch_taken ? pc + bofs_ext * addr_t'(WORD_BYTES)
		: pc + addr_t'(WORD_BYTES);

	assign retire = (state == S_EXEC && !is_mem && opcode != OP_HALT) ||
		(state == S_MEM && mem_done);

	assign mem_req = (state == S_EXEC) && is_mem;
	assign mem_write = (opcode == OP_SW);
	assign mem_addr = rd_data_a + imm_ext;
	assign mem_wdata = rd_data_b;

	assign wr_en = retire && writes_rt;
	assign wr_addr = rt;
	assign wr_data = (opcode == OP_LW) ? mem_rdata : alu_result;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= S_WAIT;
			alu_overflow <= 1'b0;
		end else begin
			case (state)
				S_WAIT: begin
					if (instr_valid) begin
						state <= S_EXEC;
					end
				end
				S_EXEC: begin
					if (opcode == OP_HALT) begin
						state <= S_HALT;
					end else if (is_mem) begin
						state <= S_MEM;
					end else begin
						state <= S_WAIT;
					end
				end
				S_MEM: begin
					if (mem_done) begin
						state <= S_WAIT;
					end
				end
				// stuck until reset
				S_HALT: state <= S_HALT;
				default: state <= S_WAIT;
			endcase
			// sticky until reset
			if (state == S_EXEC && ovf_now) begin
				alu_overflow <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
	input  logic clock,
	input  logic rst,
	input  logic mem_req,
	input  logic mem_write,
	input  bus_pkg::addr_t mem_addr,
	input  bus_pkg::data_t mem_wdata,
	input  bus_pkg::data_t dbus_dat_r,
	input  logic dbus_ack,
	output logic dbus_cyc,
	output logic dbus_stb,
	output logic dbus_we,
	output bus_pkg::addr_t dbus_adr,
	output bus_pkg::data_t dbus_dat_w,
	output logic mem_done,
	output bus_pkg::data_t mem_rdata
);
	import bus_pkg::*;

	logic busy;
	logic write_q;
	addr_t adr_q;
	data_t wdata_q;
	data_t rdata_q;

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			mem_done <= 1'b0;
		end else begin
			mem_done <= 1'b0;
			if (!busy && mem_req) begin
				busy <= 1'b1;
			end else if (busy && dbus_ack) begin
				// bus cycle ends, done follows one cycle later
				busy <= 1'b0;
				mem_done <= 1'b1;
			end
		end
	end

	// request and read data registers
	always_ff @(posedge clock) begin
		if (!busy && mem_req) begin
			write_q <= mem_write;
			adr_q <= mem_addr;
			wdata_q <= mem_wdata;
		end
		if (busy && dbus_ack) begin
			rdata_q <= dbus_dat_r;
		end
	end

	assign dbus_cyc = busy;
	assign dbus_stb = busy;
	assign dbus_we = busy && write_q;
	assign dbus_adr = adr_q;
	assign dbus_dat_w = wdata_q;
	assign mem_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== logic/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu #(
	parameter bus_pkg::addr_t RESET_PC = '0
) (
	input  logic clock,
	input  logic rst,
	output logic alu_overflow,

	output logic ibus_cyc,
	output logic ibus_stb,
	output bus_pkg::addr_t ibus_adr,
	input  bus_pkg::data_t ibus_dat_r,
	input  logic ibus_ack,

	output logic dbus_cyc,
	output logic dbus_stb,
	output logic dbus_we,
	output bus_pkg::addr_t dbus_adr,
	output bus_pkg::data_t dbus_dat_w,
	input  bus_pkg::data_t dbus_dat_r,
	input  logic dbus_ack
);
	import isa_pkg::*;
	import bus_pkg::*;

	// fetch <-> execute
	logic instr_valid;
	instr_t instr;
	addr_t pc;
	logic retire;
	addr_t next_pc;

	// execute <-> register file
	reg_addr_t rd_addr_a;
	reg_addr_t rd_addr_b;
	word_t rd_data_a;
	word_t rd_data_b;
	logic wr_en;
	reg_addr_t wr_addr;
	word_t wr_data;

	// execute <-> load/store
	logic mem_req;
	logic mem_write;
	addr_t mem_addr;
	data_t mem_wdata;
	logic mem_done;
	data_t mem_rdata;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clock(clock),
		.rst(rst),
		.retire(retire),
		.next_pc(next_pc),
		.ibus_dat_r(ibus_dat_r),
		.ibus_ack(ibus_ack),
		.ibus_cyc(ibus_cyc),
		.ibus_stb(ibus_stb),
		.ibus_adr(ibus_adr),
		.instr_valid(instr_valid),
		.instr(instr),
		.pc(pc)
	);

	exec_unit u_exec (
		.clock(clock),
		.rst(rst),
		.instr_valid(instr_valid),
		.instr(instr),
		.pc(pc),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.mem_done(mem_done),
		.mem_rdata(mem_rdata),
		.retire(retire),
		.next_pc(next_pc),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.mem_req(mem_req),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.alu_overflow(alu_overflow)
	);

	regfile u_regfile (
		.clock(clock),
		.rst(rst),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b)
	);

	load_store_unit u_lsu (
		.clock(clock),
		.rst(rst),
		.mem_req(mem_req),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.dbus_dat_r(dbus_dat_r),
		.dbus_ack(dbus_ack),
		.dbus_cyc(dbus_cyc),
		.dbus_stb(dbus_stb),
		.dbus_we(dbus_we),
		.dbus_adr(dbus_adr),
		.dbus_dat_w(dbus_dat_w),
		.mem_done(mem_done),
		.mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
	import isa_pkg::*;
	import bus_pkg::*;

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 128;
	localparam int WAIT_LIMIT = 400;

	logic clock = 1'b0;
	logic rst;
	logic alu_overflow;
	logic ibus_cyc;
	logic ibus_stb;
	addr_t ibus_adr;
	data_t ibus_dat_r;
	logic ibus_ack;
	logic dbus_cyc;
	logic dbus_stb;
	logic dbus_we;
	addr_t dbus_adr;
	data_t dbus_dat_w;
	data_t dbus_dat_r;
	logic dbus_ack;

	data_t imem [IMEM_WORDS];
	data_t dmem [DMEM_WORDS];
	int wait_tab [64];
	int i_wait;
	int i_idx;
	int d_wait;
	int d_idx;

	// completed bus transfers
	addr_t fetch_log [$];
	addr_t wr_adr_log [$];
	data_t wr_dat_log [$];
	addr_t exp_adr_q [$];
	data_t exp_dat_q [$];

	int prog_len;
	int errors;
	int checks;
	int tests;
	logic timed_out;

	cpu #(
		.RESET_PC('0)
	) dut (
		.clock(clock),
		.rst(rst),
		.alu_overflow(alu_overflow),
		.ibus_cyc(ibus_cyc),
		.ibus_stb(ibus_stb),
		.ibus_adr(ibus_adr),
		.ibus_dat_r(ibus_dat_r),
		.ibus_ack(ibus_ack),
		.dbus_cyc(dbus_cyc),
		.dbus_stb(dbus_stb),
		.dbus_we(dbus_we),
		.dbus_adr(dbus_adr),
		.dbus_dat_w(dbus_dat_w),
		.dbus_dat_r(dbus_dat_r),
		.dbus_ack(dbus_ack)
	);

	always #50 clock = ~clock;

	// instruction memory slave
	always @(posedge clock) begin
		if (rst) begin
			ibus_ack <= 1'b0;
		end else if (ibus_ack) begin
			ibus_ack <= 1'b0;
			fetch_log.push_back(ibus_adr);
			i_wait <= wait_tab[i_idx];
			i_idx <= (i_idx + 1) % 64;
		end else if (ibus_cyc && ibus_stb) begin
			if (i_wait == 0) begin
				ibus_ack <= 1'b1;
				ibus_dat_r <= imem[(ibus_adr / WORD_BYTES) % IMEM_WORDS];
			end else begin
				i_wait <= i_wait - 1;
			end
		end
	end

	// data memory slave that writes when the transfer completes
	always @(posedge clock) begin
		if (rst) begin
			dbus_ack <= 1'b0;
		end else if (dbus_ack) begin
			dbus_ack <= 1'b0;
			if (dbus_we) begin
				dmem[(dbus_adr / WORD_BYTES) % DMEM_WORDS] <= dbus_dat_w;
				wr_adr_log.push_back(dbus_adr);
				wr_dat_log.push_back(dbus_dat_w);
			end
			d_wait <= wait_tab[d_idx];
			d_idx <= (d_idx + 1) % 64;
		end else if (dbus_cyc && dbus_stb) begin
			if (d_wait == 0) begin
				dbus_ack <= 1'b1;
				dbus_dat_r <= dmem[(dbus_adr / WORD_BYTES) % DMEM_WORDS];
			end else begin
				d_wait <= d_wait - 1;
			end
		end
	end

	function automatic instr_t enc_reg(opcode_t op, int rt, int ra, int rb, alu_op_t sub);
		return {1'b0, 6'(op), 5'(rt), 5'(ra), 5'(rb), 5'b0, 5'(sub)};
	endfunction

	function automatic instr_t enc_imm(opcode_t op, int rt, int ra, int imm);
		return {1'b0, 6'(op), 5'(rt), 5'(ra), 15'(imm)};
	endfunction

	function automatic instr_t enc_beq(int rt, int ra, int ofs);
		return {1'b0, 6'(OP_BEQ), 5'(rt), 5'(ra), 1'b0, 14'(ofs)};
	endfunction

	function automatic data_t fill_word(int i);
		return {16'hd47a, 16'(i)} ^ (data_t'(i) << 20);
	endfunction

	task automatic check_addr(string name, addr_t got, addr_t exp);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_data(string name, data_t got, data_t exp);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// refill both memories and start an empty program
	task automatic start_program();
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = enc_imm(OP_HALT, 0, 0, i);
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = fill_word(i);
		end
		prog_len = 0;
		exp_adr_q.delete();
		exp_dat_q.delete();
	endtask

	task automatic put(instr_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic expect_write(addr_t adr, data_t dat);
		exp_adr_q.push_back(adr);
		exp_dat_q.push_back(dat);
	endtask

	task automatic pulse_reset();
		fetch_log.delete();
		wr_adr_log.delete();
		wr_dat_log.delete();
		@(posedge clock);
		rst <= 1'b1;
		repeat (5) @(posedge clock);
		rst <= 1'b0;
		@(negedge clock);
	endtask

	task automatic wait_fetches(int n);
		int cnt;
		cnt = 0;
		while (fetch_log.size() < n && cnt < WAIT_LIMIT) begin
			@(negedge clock);
			cnt++;
		end
		if (fetch_log.size() < n) begin
			$display("timeout: %0d of %0d instruction fetches completed in %0d cycles",
				fetch_log.size(), n, WAIT_LIMIT);
			timed_out = 1'b1;
		end
	endtask

	task automatic compare_writes();
		if (wr_adr_log.size() != exp_adr_q.size()) begin
			$display("data port saw %0d writes where %0d were expected",
				wr_adr_log.size(), exp_adr_q.size());
			errors++;
		end
		for (int i = 0; i < wr_adr_log.size() && i < exp_adr_q.size(); i++) begin
			check_addr("dbus_adr", wr_adr_log[i], exp_adr_q[i]);
			check_data("dbus_dat_w", wr_dat_log[i], exp_dat_q[i]);
		end
	endtask

	task automatic finish_test(string name, int errors_before);
		tests++;
		$display("test %0d %s: %0d mismatches", tests, name, errors - errors_before);
	endtask

	task automatic test_reset_state();
		int e0;
		e0 = errors;
		start_program();
		put(enc_imm(OP_HALT, 0, 0, 0));
		pulse_reset();
		check_bit("alu_overflow", alu_overflow, 1'b0);
		check_bit("ibus_cyc", ibus_cyc, 1'b0);
		check_bit("ibus_stb", ibus_stb, 1'b0);
		check_bit("dbus_cyc", dbus_cyc, 1'b0);
		check_bit("dbus_stb", dbus_stb, 1'b0);
		check_bit("dbus_we", dbus_we, 1'b0);
		wait_fetches(1);
		if (!timed_out) begin
			check_addr("ibus_adr", fetch_log[0], addr_t'(0));
		end
		finish_test("reset_state", e0);
	endtask

	task automatic test_alu_program();
		word_t r [32];
		int e0;
		e0 = errors;
		start_program();
		r[1] = 1234;
		r[2] = -300;
		r[3] = r[1] + r[2];
		r[4] = r[1] - r[2];
		r[5] = r[1] & r[2];
		r[6] = r[1] | r[2];
		r[7] = r[1] ^ r[2];
		r[8] = ($signed(r[2]) < $signed(r[1])) ? 1 : 0;
		r[9] = ($signed(r[1]) < $signed(r[2])) ? 1 : 0;
		put(enc_imm(OP_ADDI, 1, 0, 1234));
		put(enc_imm(OP_ADDI, 2, 0, -300));
		put(enc_reg(OP_ALU, 3, 1, 2, ALU_ADD));
		put(enc_reg(OP_ALU, 4, 1, 2, ALU_SUB));
		put(enc_reg(OP_ALU, 5, 1, 2, ALU_AND));
		put(enc_reg(OP_ALU, 6, 1, 2, ALU_OR));
		put(enc_reg(OP_ALU, 7, 1, 2, ALU_XOR));
		put(enc_reg(OP_ALU, 8, 2, 1, ALU_SLT));
		put(enc_reg(OP_ALU, 9, 1, 2, ALU_SLT));
		for (int k = 3; k <= 9; k++) begin
			put(enc_imm(OP_SW, k, 0, 'h40 + WORD_BYTES * (k - 3)));
			expect_write(addr_t'('h40 + WORD_BYTES * (k - 3)), r[k]);
		end
		put(enc_imm(OP_HALT, 0, 0, 0));
		pulse_reset();
		wait_fetches(prog_len);
		if (!timed_out) begin
			compare_writes();
		end
		finish_test("alu_program", e0);
	endtask

	task automatic test_load_store_round_trip();
		int e0;
		e0 = errors;
		start_program();
		put(enc_imm(OP_ADDI, 1, 0, 'h2bcd));
		put(enc_imm(OP_SW, 1, 0, 'h80));
		put(enc_imm(OP_LW, 2, 0, 'h80));
		put(enc_imm(OP_SW, 2, 0, 'h84));
		put(enc_imm(OP_LW, 3, 0, 'h90));
		put(enc_imm(OP_SW, 3, 0, 'h94));
		put(enc_imm(OP_HALT, 0, 0, 0));
		expect_write('h80, 'h2bcd);
		expect_write('h84, 'h2bcd);
		expect_write('h94, fill_word('h90 / WORD_BYTES));
		pulse_reset();
		wait_fetches(prog_len);
		if (!timed_out) begin
			compare_writes();
			check_data("dmem[0x84]", dmem['h84 / WORD_BYTES], 'h2bcd);
		end
		finish_test("load_store_round_trip", e0);
	endtask

	task automatic test_branches();
		addr_t exp_pc [$];
		int e0;
		e0 = errors;
		start_program();
		put(enc_imm(OP_ADDI, 1, 0, 5));
		put(enc_imm(OP_ADDI, 2, 0, 5));
		// taken branch skips two words
		put(enc_beq(1, 2, 3));
		put(enc_imm(OP_ADDI, 3, 0, 1));
		put(enc_imm(OP_ADDI, 3, 0, 2));
		put(enc_imm(OP_ADDI, 4, 0, 6));
		// 6 against 5 falls through
		put(enc_beq(4, 1, 2));
		put(enc_imm(OP_HALT, 0, 0, 0));
		exp_pc = '{0, 4, 8};
		exp_pc.push_back(addr_t'(8 + 3 * WORD_BYTES));
		exp_pc.push_back(exp_pc[3] + WORD_BYTES);
		exp_pc.push_back(exp_pc[4] + WORD_BYTES);
		pulse_reset();
		wait_fetches(exp_pc.size());
		if (!timed_out) begin
			repeat (10) @(negedge clock);
			if (fetch_log.size() != exp_pc.size()) begin
				$display("%0d instruction fetches seen, %0d expected",
					fetch_log.size(), exp_pc.size());
				errors++;
			end
			for (int i = 0; i < exp_pc.size(); i++) begin
				check_addr("ibus_adr", fetch_log[i], exp_pc[i]);
			end
		end
		finish_test("branches", e0);
	endtask

	task automatic test_sticky_overflow();
		int e0;
		e0 = errors;
		start_program();
		dmem['h100 / WORD_BYTES] = 32'h7fff_ffff;
		put(enc_imm(OP_LW, 1, 0, 'h100));
		put(enc_imm(OP_ADDI, 2, 1, 1));
		put(enc_reg(OP_ALU, 3, 0, 0, ALU_ADD));
		put(enc_imm(OP_ADDI, 4, 0, 7));
		put(enc_imm(OP_SW, 4, 0, 'h104));
		put(enc_imm(OP_HALT, 0, 0, 0));
		expect_write('h104, 7);
		pulse_reset();
		wait_fetches(2);
		if (!timed_out) begin
			check_bit("alu_overflow", alu_overflow, 1'b0);
			wait_fetches(3);
		end
		if (!timed_out) begin
			check_bit("alu_overflow", alu_overflow, 1'b1);
			wait_fetches(prog_len);
		end
		if (!timed_out) begin
			check_bit("alu_overflow", alu_overflow, 1'b1);
			compare_writes();
			pulse_reset();
			check_bit("alu_overflow", alu_overflow, 1'b0);
		end
		finish_test("sticky_overflow", e0);
	endtask

	task automatic test_halt_stops_bus();
		int e0;
		e0 = errors;
		start_program();
		put(enc_imm(OP_ADDI, 1, 0, 9));
		put(enc_imm(OP_SW, 1, 0, 'h20));
		put(enc_imm(OP_HALT, 0, 0, 0));
		expect_write('h20, 9);
		pulse_reset();
		wait_fetches(prog_len);
		if (!timed_out) begin
			for (int i = 0; i < 50; i++) begin
				@(negedge clock);
				check_bit("ibus_cyc", ibus_cyc, 1'b0);
				check_bit("ibus_stb", ibus_stb, 1'b0);
				check_bit("dbus_cyc", dbus_cyc, 1'b0);
				check_bit("dbus_stb", dbus_stb, 1'b0);
			end
			if (fetch_log.size() != prog_len) begin
				$display("instruction fetches continued after halt");
				errors++;
			end
			compare_writes();
		end
		finish_test("halt_stops_bus", e0);
	endtask

	initial begin
		rst = 1'b1;
		ibus_ack = 1'b0;
		ibus_dat_r = '0;
		dbus_ack = 1'b0;
		dbus_dat_r = '0;
		i_wait = 0;
		d_wait = 0;
		i_idx = 0;
		d_idx = 32;
		errors = 0;
		checks = 0;
		tests = 0;
		timed_out = 1'b0;
		void'($urandom(32'h3d2e98af));
		// 0 to 3 wait states per transfer
		for (int i = 0; i < 64; i++) begin
			wait_tab[i] = $urandom % 4;
		end
		test_reset_state();
		if (!timed_out) test_alu_program();
		if (!timed_out) test_load_store_round_trip();
		if (!timed_out) test_branches();
		if (!timed_out) test_sticky_overflow();
		if (!timed_out) test_halt_stops_bus();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
logic/isa_pkg.sv
logic/bus_pkg.sv
logic/regfile.sv
logic/fetch_unit.sv
logic/exec_unit.sv
logic/load_store_unit.sv
logic/cpu.sv
verification/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - logic/isa_pkg.sv
  - logic/bus_pkg.sv
  - logic/regfile.sv
  - logic/fetch_unit.sv
  - logic/exec_unit.sv
  - logic/load_store_unit.sv
  - logic/cpu.sv
  - target: test
    files:
      - verification/cpu_tb.sv
